//--- design/ppu_pkg.sv
package ppu_pkg;

	localparam int LINE_CYCLES     = 456;
	localparam int FRAME_LINES     = 154;
	localparam int VISIBLE_LINES   = 144;
	localparam int OAM_CYCLES      = 80;  // Mode 2 length; pixel transfer starts right after.
	localparam int SCREEN_WIDTH    = 160;
	localparam int TILE_ROW_PIXELS = 8;
	localparam int FIFO_DEPTH      = 16;

	// Offset into the 8 KB video memory.
	typedef logic [12:0] vram_addr_t;

	localparam vram_addr_t MAP_LOW_BASE     = 13'h1800;
	localparam vram_addr_t MAP_HIGH_BASE    = 13'h1C00;
	localparam vram_addr_t SIGNED_TILE_BASE = 13'h1000;  // Tile number 0 in the signed area.

	localparam logic [3:0] REG_LCDC = 4'h0;
	localparam logic [3:0] REG_STAT = 4'h1;
	localparam logic [3:0] REG_SCY  = 4'h2;
	localparam logic [3:0] REG_SCX  = 4'h3;
	localparam logic [3:0] REG_LY   = 4'h4;
	localparam logic [3:0] REG_LYC  = 4'h5;
	localparam logic [3:0] REG_BGP  = 4'h7;

	// Encoding matches the two low bits of STAT.
	typedef enum logic [1:0] {
		HBLANK         = 2'd0,
		VBLANK         = 2'd1,
		OAM_SEARCH     = 2'd2,
		PIXEL_TRANSFER = 2'd3
	} ppu_mode_t;

	typedef struct packed {
		logic ppu_ena;
		logic win_map;   // Stored for readback only.
		logic win_ena;   // Stored for readback only.
		logic bg_tiles;  // 1 selects the unsigned tile area at 0x0000.
		logic bg_map;    // 1 selects the map at 0x1C00.
		logic obj_size;  // Stored for readback only.
		logic obj_ena;   // Stored for readback only.
		logic bg_ena;
	} lcdc_t;

	typedef struct packed {
		lcdc_t      lcdc;
		logic       sel_lyc;
		logic       sel_mode2;
		logic       sel_mode1;
		logic       sel_mode0;
		logic [7:0] scy;
		logic [7:0] scx;
		logic [7:0] lyc;
		logic [7:0] bgp;
	} ppu_cfg_t;

	typedef struct packed {
		logic [8:0] lx;
		logic [7:0] ly;
		ppu_mode_t  mode;
		logic       lyc_eq;
	} line_pos_t;

	// Bit 7 of each plane is the leftmost pixel.
	typedef struct packed {
		logic [7:0] lo;
		logic [7:0] hi;
	} tile_row_t;

endpackage

//--- design/ppu_regs.sv
module ppu_regs (
	input  logic                clk,
	input  logic                reset,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  logic [3:0]          wb_adr,
	input  logic [7:0]          wb_dat_i,
	output logic [7:0]          wb_dat_o,
	output logic                wb_ack,
	input  ppu_pkg::line_pos_t  pos,
	output ppu_pkg::ppu_cfg_t   cfg,
	output logic                irq_stat
);
	import ppu_pkg::*;

	logic       req;
	logic [7:0] rd_data;
	logic       stat_sig;
	logic       stat_q;

	// A new request is one the slave has not acknowledged yet.
	assign req = wb_cyc && wb_stb && !wb_ack;

	always_comb begin
		case (wb_adr)
			REG_LCDC: rd_data = cfg.lcdc;
			REG_STAT: rd_data = {1'b1, cfg.sel_lyc, cfg.sel_mode2, cfg.sel_mode1,
				cfg.sel_mode0, pos.lyc_eq, pos.mode};
			REG_SCY:  rd_data = cfg.scy;
			REG_SCX:  rd_data = cfg.scx;
			REG_LY:   rd_data = pos.ly;
			REG_LYC:  rd_data = cfg.lyc;
			REG_BGP:  rd_data = cfg.bgp;
			default:  rd_data = 8'hFF;  // Unused offsets float high.
		endcase
	end

	// Mode 1 is also flagged by the mode 2 select, like the original hardware.
	assign stat_sig = cfg.lcdc.ppu_ena && (
		(pos.lyc_eq && cfg.sel_lyc) ||
		(pos.mode == HBLANK && cfg.sel_mode0) ||
		(pos.mode == VBLANK && (cfg.sel_mode1 || cfg.sel_mode2)) ||
		(pos.mode == OAM_SEARCH && cfg.sel_mode2));

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack   <= 1'b0;
			cfg      <= '0;  // Display comes up off.
			stat_q   <= 1'b0;
			irq_stat <= 1'b0;
		end else begin
			wb_ack   <= req;
			stat_q   <= stat_sig;
			irq_stat <= stat_sig && !stat_q;  // Rising edge only.
			if (req && wb_we) begin
				case (wb_adr)
					REG_LCDC: cfg.lcdc <= wb_dat_i;
					REG_STAT: begin
						cfg.sel_lyc   <= wb_dat_i[6];
						cfg.sel_mode2 <= wb_dat_i[5];
						cfg.sel_mode1 <= wb_dat_i[4];
						cfg.sel_mode0 <= wb_dat_i[3];
					end
					REG_SCY:  cfg.scy <= wb_dat_i;
					REG_SCX:  cfg.scx <= wb_dat_i;
					REG_LYC:  cfg.lyc <= wb_dat_i;
					REG_BGP:  cfg.bgp <= wb_dat_i;
					default: ;  // LY and the unused offsets are read only.
				endcase
			end
		end
	end

	// Read data is sampled with the request and held through the ack cycle.
	always_ff @(posedge clk) begin
		if (req && !wb_we)
			wb_dat_o <= rd_data;
	end

	// The master must drop stb after an ack, so no cycle is acknowledged twice.
	assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_stb);

endmodule

//--- design/ppu_timing.sv
module ppu_timing (
	input  logic                clk,
	input  logic                reset,
	input  ppu_pkg::ppu_cfg_t   cfg,
	input  logic                line_done,
	output ppu_pkg::line_pos_t  pos,
	output logic                line_start,
	output logic                irq_vblank
);
	import ppu_pkg::*;

	logic       end_of_line;
	logic [8:0] lx_next;
	logic [7:0] ly_next;
	ppu_mode_t  mode_next;

	assign end_of_line = pos.lx == 9'(LINE_CYCLES - 1);

	always_comb begin
		lx_next = end_of_line ? 9'd0 : pos.lx + 9'd1;
		ly_next = pos.ly;
		if (end_of_line)
			ly_next = (pos.ly == 8'(FRAME_LINES - 1)) ? 8'd0 : pos.ly + 8'd1;

		if (ly_next >= 8'(VISIBLE_LINES))
			mode_next = VBLANK;
		else if (lx_next < 9'(OAM_CYCLES))
			mode_next = OAM_SEARCH;
		else if (lx_next == 9'(OAM_CYCLES))
			mode_next = PIXEL_TRANSFER;
		else if (line_done)
			mode_next = HBLANK;  // Transfer length depends on the FIFO.
		else
			mode_next = pos.mode;
	end

	// A display that is switched off sits at the top left in mode 0.
	always_ff @(posedge clk) begin
		if (reset || !cfg.lcdc.ppu_ena) begin
			pos        <= '0;
			line_start <= 1'b0;
			irq_vblank <= 1'b0;
		end else begin
			pos.lx     <= lx_next;
			pos.ly     <= ly_next;
			pos.mode   <= mode_next;
			pos.lyc_eq <= ly_next == cfg.lyc;
			line_start <= lx_next == 9'(OAM_CYCLES) && ly_next < 8'(VISIBLE_LINES);
			irq_vblank <= lx_next == 9'd0 && ly_next == 8'(VISIBLE_LINES);
		end
	end

	// The FIFO only finishes a line that the fetcher is still working on.
	assert property (@(posedge clk) disable iff (reset)
		line_done |-> pos.mode == PIXEL_TRANSFER);

	// Fetch and drain must fit inside one line.
	assert property (@(posedge clk) disable iff (reset)
		pos.mode == PIXEL_TRANSFER |-> !end_of_line);

endmodule

//--- design/bg_fetcher.sv
module bg_fetcher (
	input  logic                clk,
	input  logic                reset,
	input  ppu_pkg::ppu_cfg_t   cfg,
	input  ppu_pkg::line_pos_t  pos,
	input  logic                line_start,
	input  logic                row_ready,
	output logic                row_valid,
	output ppu_pkg::tile_row_t  row,
	output logic                vram_rd,
	output ppu_pkg::vram_addr_t vram_addr,
	input  logic [7:0]          vram_data
);
	import ppu_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		TILE,
		LO_ADDR,
		LO_DATA,
		HI_ADDR,
		HI_DATA,
		BLOCK
	} fetch_state_t;

	fetch_state_t state;
	logic         fetching;
	logic [7:0]   line;
	logic [4:0]   col;
	logic [7:0]   tile;
	vram_addr_t   map_addr;

	// Byte address of one bitplane of one tile row.
	function automatic vram_addr_t row_addr(input logic [7:0] num, input logic [2:0] fine_y,
			input logic unsigned_area, input logic plane);
		vram_addr_t offs;
		offs = {1'b0, num, fine_y, plane};
		if (!unsigned_area)
			offs = SIGNED_TILE_BASE + {num[7], num, fine_y, plane};  // Tile number is signed.
		return offs;
	endfunction

	assign fetching = pos.mode == PIXEL_TRANSFER;
	assign line = cfg.scy + pos.ly;  // Wraps around the 256-line map.
	assign map_addr = (cfg.lcdc.bg_map ? MAP_HIGH_BASE : MAP_LOW_BASE) + {3'b000, line[7:3], col};
	assign row_valid = state == BLOCK;

	always_comb begin
		vram_rd   = 1'b0;
		vram_addr = map_addr;
		case (state)
			TILE: vram_rd = fetching;
			LO_ADDR: begin
				vram_rd   = fetching;
				vram_addr = row_addr(vram_data, line[2:0], cfg.lcdc.bg_tiles, 1'b0);  // Map byte.
			end
			HI_ADDR: begin
				vram_rd   = fetching;
				vram_addr = row_addr(tile, line[2:0], cfg.lcdc.bg_tiles, 1'b1);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || !fetching) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:    if (line_start) state <= TILE;
				TILE:    state <= LO_ADDR;
				LO_ADDR: state <= LO_DATA;
				LO_DATA: state <= HI_ADDR;
				HI_ADDR: state <= HI_DATA;
				HI_DATA: state <= BLOCK;
				BLOCK:   if (row_ready) state <= TILE;  // Wait for room in the FIFO.
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (line_start)
			col <= cfg.scx[7:3];
		else if (row_valid && row_ready)
			col <= col + 5'd1;  // Map rows wrap at 32 tiles.
		if (state == LO_ADDR)
			tile <= vram_data;
		if (state == LO_DATA)
			row.lo <= vram_data;
		if (state == HI_DATA)
			row.hi <= vram_data;
	end

endmodule

//--- design/pixel_fifo.sv
module pixel_fifo (
	input  logic                clk,
	input  logic                reset,
	input  ppu_pkg::ppu_cfg_t   cfg,
	input  logic                line_start,
	input  logic                row_valid,
	input  ppu_pkg::tile_row_t  row,
	output logic                row_ready,
	output logic                pixel_valid,
	output logic [1:0]          shade,
	output logic                line_done
);
	import ppu_pkg::*;

	logic [15:0] lo_sr;
	logic [15:0] hi_sr;
	logic [4:0]  count;
	logic [2:0]  drop;
	logic [7:0]  px_cnt;
	logic        active;
	logic        take;
	logic        shift;
	logic        emit;
	logic        last;
	logic [1:0]  color;

	assign row_ready = count <= 5'(FIFO_DEPTH - TILE_ROW_PIXELS);
	assign take = row_valid && row_ready;

	// Keeping one row in reserve lets the fetcher refill without a gap.
	assign shift = active && cfg.lcdc.ppu_ena && count > 5'(TILE_ROW_PIXELS);
	assign emit = shift && drop == 3'd0;
	assign last = emit && px_cnt == 8'(SCREEN_WIDTH - 1);
	assign color = {hi_sr[15], lo_sr[15]};

	always_ff @(posedge clk) begin
		if (reset) begin
			active      <= 1'b0;
			count       <= '0;
			drop        <= '0;
			px_cnt      <= '0;
			pixel_valid <= 1'b0;
			line_done   <= 1'b0;
		end else begin
			pixel_valid <= emit;
			line_done   <= last;  // Goes high with the last pixel of the line.
			if (line_start) begin
				active <= 1'b1;
				count  <= '0;
				drop   <= cfg.scx[2:0];  // Fine scroll pixels to throw away.
				px_cnt <= '0;
			end else begin
				if (last || !cfg.lcdc.ppu_ena)
					active <= 1'b0;
				if (take)
					count <= count + 5'(TILE_ROW_PIXELS);
				else if (shift)
					count <= count - 5'd1;
				if (shift && drop != 3'd0)
					drop <= drop - 3'd1;
				if (emit)
					px_cnt <= px_cnt + 8'd1;
			end
		end
	end

	// Pixel 0 sits in bit 15 and a new row lands right behind the last held pixel.
	always_ff @(posedge clk) begin
		if (line_start) begin
			lo_sr <= '0;
			hi_sr <= '0;
		end else if (take) begin
			lo_sr <= lo_sr | ({row.lo, 8'h00} >> count);
			hi_sr <= hi_sr | ({row.hi, 8'h00} >> count);
		end else if (shift) begin
			lo_sr <= {lo_sr[14:0], 1'b0};
			hi_sr <= {hi_sr[14:0], 1'b0};
		end
		shade <= cfg.bgp[{color, 1'b0} +: 2];
	end

	// A new line only starts once the previous one has sent all its pixels.
	assert property (@(posedge clk) disable iff (reset) line_start |-> !active);

endmodule

//--- design/lcd_ppu.sv
module lcd_ppu (
	input  logic                clk,
	input  logic                reset,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  logic [3:0]          wb_adr,
	input  logic [7:0]          wb_dat_i,
	output logic [7:0]          wb_dat_o,
	output logic                wb_ack,
	output logic                irq_vblank,
	output logic                irq_stat,
	output logic                vram_rd,
	output ppu_pkg::vram_addr_t vram_addr,
	input  logic [7:0]          vram_data,
	output logic                line_start,
	output logic                pixel_valid,
	output logic [1:0]          shade
);
	import ppu_pkg::*;

	ppu_cfg_t  cfg;
	line_pos_t pos;
	logic      line_done;
	logic      row_valid;
	logic      row_ready;
	tile_row_t row;

	ppu_regs regs (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
		.pos(pos), .cfg(cfg), .irq_stat(irq_stat)
	);

	ppu_timing timing (
		.clk(clk), .reset(reset), .cfg(cfg), .line_done(line_done),
		.pos(pos), .line_start(line_start), .irq_vblank(irq_vblank)
	);

	bg_fetcher fetcher (
		.clk(clk), .reset(reset), .cfg(cfg), .pos(pos), .line_start(line_start),
		.row_ready(row_ready), .row_valid(row_valid), .row(row),
		.vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data)
	);

	pixel_fifo fifo (
		.clk(clk), .reset(reset), .cfg(cfg), .line_start(line_start),
		.row_valid(row_valid), .row(row), .row_ready(row_ready),
		.pixel_valid(pixel_valid), .shade(shade), .line_done(line_done)
	);

endmodule

//--- bench/tb_vram.sv
module tb_vram (
	input  logic        clk,
	input  logic        rd,
	input  logic [12:0] addr,
	output logic [7:0]  data
);
	timeunit 1ns;
	timeprecision 100ps;

	// 8 KB of video memory, filled by the test top before reset ends.
	logic [7:0] mem [0:8191];
	int         bad_addr;

	initial begin
		data     = 8'h00;
		bad_addr = 0;
	end

	// The read is taken on the edge that ends the request cycle and the byte shows up
	// shortly after it, so it is stable for the whole following cycle.
	always @(posedge clk) begin
		if (rd)
			data <= #1 mem[addr];
	end

	// An unknown address would make the pixel model meaningless.
	always @(negedge clk) begin
		if (rd) begin
			assert (!$isunknown(addr)) else begin
				$display("video memory read with an unknown address");
				bad_addr++;
			end
		end
	end

endmodule

//--- bench/tb_ppu.sv
module tb_ppu;
	timeunit 1ns;
	timeprecision 100ps;

	logic        clk;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [3:0]  wb_adr;
	logic [7:0]  wb_dat_i;
	logic [7:0]  wb_dat_o;
	logic        wb_ack;
	logic        irq_vblank;
	logic        irq_stat;
	logic        vram_rd;
	logic [12:0] vram_addr;
	logic [7:0]  vram_data;
	logic        line_start;
	logic        pixel_valid;
	logic [1:0]  shade;

	logic [31:0] rng_state;
	int          errors;
	int          cycle;
	logic        track;         // Monitor checks lines, pixels and frame timing.
	logic        quiet;         // Monitor flags any activity of a switched off display.
	int          line_cnt;
	int          pix_cnt;
	int          last_line_start;
	int          last_vblank;
	int          stat_cnt;
	int          cur_scx;
	int          cur_scy;
	int          cur_bgp;
	int          cur_map;
	int          cur_tiles;

	lcd_ppu UUT (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
		.irq_vblank(irq_vblank), .irq_stat(irq_stat),
		.vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data),
		.line_start(line_start), .pixel_valid(pixel_valid), .shade(shade)
	);

	tb_vram vram (.clk(clk), .rd(vram_rd), .addr(vram_addr), .data(vram_data));

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic check_value(input string name, input int exp, input int act);
		assert (exp == act) else begin
			$display("error: %s expected %0h actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report(input string what);
		$display("%s", what);
		errors++;
	endtask

	// Shade of screen pixel (x, y) from the map, the tile data and BGP.
	function automatic int expected_shade(input int x, input int y);
		int line;
		int mx;
		int a;
		int tile;
		int lo;
		int hi;
		int p;
		int color;
		line = (cur_scy + y) % 256;
		mx = (cur_scx + x) % 256;
		a = (cur_map != 0 ? 'h1C00 : 'h1800) + (line / 8) * 32 + mx / 8;
		tile = int'(vram.mem[a]);
		if (cur_tiles != 0)
			a = tile * 16 + (line % 8) * 2;
		else
			a = 'h1000 + (tile >= 128 ? tile - 256 : tile) * 16 + (line % 8) * 2;
		lo = int'(vram.mem[a]);
		hi = int'(vram.mem[a + 1]);
		p = 7 - mx % 8;
		color = ((hi >> p) & 1) * 2 + ((lo >> p) & 1);
		return (cur_bgp >> (2 * color)) & 3;
	endfunction

	task automatic bus_write(input logic [3:0] adr, input logic [7:0] data);
		int t;
		@(posedge clk);
		#1;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_i = data;
		for (t = 0; t < 20; t++) begin
			@(negedge clk);
			if (wb_ack)
				break;
		end
		if (t == 20)
			report("timeout: no ack for a register write");
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic bus_read(input logic [3:0] adr, output logic [7:0] data);
		int t;
		@(posedge clk);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		data   = 8'hXX;
		for (t = 0; t < 20; t++) begin
			@(negedge clk);
			if (wb_ack) begin
				data = wb_dat_o;
				break;
			end
		end
		if (t == 20)
			report("timeout: no ack for a register read");
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic await_vblank();
		int t;
		for (t = 0; t < 80000; t++) begin
			@(negedge clk);
			if (irq_vblank)
				break;
		end
		if (t == 80000)
			report("timeout: the vblank interrupt never came");
	endtask

	task automatic await_stat_irq();
		int t;
		for (t = 0; t < 80000; t++) begin
			@(negedge clk);
			if (irq_stat)
				break;
		end
		if (t == 80000)
			report("timeout: the STAT interrupt never came");
	endtask

	// Fresh bookkeeping for a display that is about to be switched on.
	task automatic restart_tracking();
		line_cnt        = 0;
		pix_cnt         = 0;
		last_line_start = -1;
		last_vblank     = -1;
		track           = 1'b1;
	endtask

	task automatic pick_config(input logic tiles);
		logic [31:0] r;
		r = next_random();
		cur_scx   = int'(r[7:0]);
		cur_scy   = int'(r[15:8]);
		cur_bgp   = int'(r[23:16]);
		cur_map   = int'(r[24]);
		cur_tiles = int'(tiles);
		bus_write(4'h3, r[7:0]);
		bus_write(4'h2, r[15:8]);
		bus_write(4'h7, r[23:16]);
		bus_write(4'h0, {1'b1, 2'b00, tiles, r[24], 3'b001});
	endtask

	// Outputs are sampled in the middle of the cycle, away from both edges.
	always @(negedge clk) begin
		cycle++;
		if (track && line_start) begin
			if (last_line_start >= 0) begin
				check_value("pixels per line", 160, pix_cnt);
				check_value("line_start spacing", 456, cycle - last_line_start);
			end
			last_line_start = cycle;
			line_cnt++;
			pix_cnt = 0;
		end
		if (track && pixel_valid) begin
			if (line_cnt == 0)
				report("pixel came out before any line_start");
			else
				check_value($sformatf("shade x=%0d y=%0d", pix_cnt, line_cnt - 1),
					expected_shade(pix_cnt, line_cnt - 1), int'(shade));
			pix_cnt++;
		end
		if (track && irq_vblank) begin
			check_value("pixels in last line", 160, pix_cnt);
			check_value("line_start pulses per frame", 144, line_cnt);
			if (last_vblank >= 0)
				check_value("vblank spacing", 456 * 154, cycle - last_vblank);
			last_vblank     = cycle;
			last_line_start = -1;
			line_cnt        = 0;
			pix_cnt         = 0;
		end
		if (irq_stat)
			stat_cnt++;
		if (quiet && (pixel_valid || vram_rd || irq_vblank || irq_stat))
			report("activity seen while the display is off");
	end

	initial begin
		logic [7:0]  rd;
		logic [7:0]  rd2;
		logic [7:0]  st;
		logic [31:0] r;
		logic [7:0]  lyc;
		int          k;

		rng_state = 32'had9b;
		errors    = 0;
		cycle     = 0;
		track     = 1'b0;
		quiet     = 1'b0;
		stat_cnt  = 0;
		reset     = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = 4'h0;
		wb_dat_i  = 8'h00;
		for (k = 0; k < 8192; k++) begin
			r = next_random();
			vram.mem[k] = r[7:0] ^ 8'(k) ^ 8'(k >> 8);
		end
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// Register access with the display off.
		bus_read(4'h4, rd);
		check_value("LY while off", 0, int'(rd));
		r = next_random();
		bus_write(4'h2, r[7:0]);
		bus_write(4'h3, r[15:8]);
		bus_write(4'h5, r[23:16]);
		bus_write(4'h7, r[31:24]);
		bus_read(4'h2, rd);
		check_value("SCY readback", int'(r[7:0]), int'(rd));
		bus_read(4'h3, rd);
		check_value("SCX readback", int'(r[15:8]), int'(rd));
		bus_read(4'h5, rd);
		check_value("LYC readback", int'(r[23:16]), int'(rd));
		bus_read(4'h7, rd);
		check_value("BGP readback", int'(r[31:24]), int'(rd));
		r = next_random();
		bus_write(4'h0, r[7:0] & 8'h7F);
		bus_write(4'h1, r[15:8]);
		bus_read(4'h0, rd);
		check_value("LCDC readback", int'(r[7:0] & 8'h7F), int'(rd));
		bus_read(4'h1, rd);
		check_value("STAT readback", int'({1'b1, r[14:11], 3'b000}), int'(rd));
		for (k = 6; k < 16; k++) begin
			if (k != 7) begin
				bus_read(4'(k), rd);
				check_value($sformatf("unused offset %0d", k), 'hFF, int'(rd));
			end
		end
		bus_read(4'h4, rd);
		check_value("LY while off", 0, int'(rd));
		bus_write(4'h1, 8'h00);

		// Frame timing, with the pixel stream checked along the way.
		restart_tracking();
		pick_config(1'b1);
		repeat (3) await_vblank();

		// Pixel stream over three random configurations.
		for (k = 0; k < 3; k++) begin
			pick_config(1'(k));
			await_vblank();
			await_vblank();
		end

		// Mode and LY readback during a running frame.
		for (k = 0; k < 8000; k++) begin
			bus_read(4'h4, rd);
			bus_read(4'h1, st);
			bus_read(4'h4, rd2);
			assert (rd <= 8'd153) else begin
				$display("error: LY range expected at most 153 actual %0d", rd);
				errors++;
			end
			if (rd == rd2)
				check_value($sformatf("mode at LY %0d", rd), rd >= 8'd144 ? 1 : 0,
					st[1:0] == 2'd1 ? 1 : 0);
		end

		// STAT interrupt on the LY compare.
		track = 1'b0;
		bus_write(4'h0, 8'h00);
		r = next_random();
		lyc = 8'(r % 144);
		bus_write(4'h5, lyc);
		bus_write(4'h1, 8'h40);
		restart_tracking();
		bus_write(4'h0, {1'b1, 2'b00, 1'(cur_tiles), 1'(cur_map), 3'b001});
		await_stat_irq();
		bus_read(4'h1, st);
		bus_read(4'h4, rd);
		check_value("lyc_eq after STAT interrupt", 1, int'(st[2]));
		check_value("LY after STAT interrupt", int'(lyc), int'(rd));
		await_vblank();
		stat_cnt = 0;
		await_vblank();
		check_value("STAT interrupts per frame", 1, stat_cnt);

		// Display off.
		track = 1'b0;
		bus_write(4'h0, 8'h11);
		repeat (3) @(negedge clk);
		quiet = 1'b1;
		for (k = 0; k < 10; k++) begin
			bus_read(4'h4, rd);
			check_value("LY while off", 0, int'(rd));
			repeat (200) @(negedge clk);
		end
		quiet = 1'b0;

		errors += vram.bad_addr;
		$display("tests done, %0d errors", errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- tb.f
design/ppu_pkg.sv
design/ppu_regs.sv
design/ppu_timing.sv
design/bg_fetcher.sv
design/pixel_fifo.sv
design/lcd_ppu.sv
bench/tb_vram.sv
bench/tb_ppu.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_ppu -f tb.f -o sim_ppu

./obj_dir/sim_ppu > sim.log
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
